/* hw/zmem_pkg.sv */
/*
 shared types and port codes for the Z80 memory paging path
 pulled in by the pagers, the DOS controller, the mapper and the top level
*/
package zmem_pkg;

	////////////////////////////////////////////////////////////////////////////
	// port codes and trap address
	////////////////////////////////////////////////////////////////////////////

	// low address byte of the pager ports
	localparam logic [7:0] PORT_RAM_PAGE = 8'hF7;
	localparam logic [7:0] PORT_ROM_PAGE = 8'hFB;
	localparam logic [7:0] PORT_WRDIS    = 8'hBF;

	// opcode fetch from this high byte in ROM turns DOS on
	localparam logic [7:0] DOS_TRAP_HI = 8'h3D;

	////////////////////////////////////////////////////////////////////////////
	// bus types
	////////////////////////////////////////////////////////////////////////////

	// one CPU memory access, at most one per fclk
	typedef struct packed {
		logic        valid;
		logic        rnw;
		logic        m1;
		logic [15:0] addr;
		logic [7:0]  wdata;
	} cpu_acc_t;

	// one I/O write, addr[15:14] picks the window
	typedef struct packed {
		logic        valid;
		logic [15:0] addr;
		logic [7:0]  data;
	} port_wr_t;

	////////////////////////////////////////////////////////////////////////////
	// window state
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [7:0] page;
	} ram_view_t;

	// dos_follow lets bit 0 of the ROM page track the DOS flag
	typedef struct packed {
		logic [1:0] reserved;
		logic       dos_follow;
		logic [4:0] rom_page;
	} rom_view_t;

	// same page byte, read one way or the other by romnram
	typedef union packed {
		ram_view_t ram;
		rom_view_t rom;
	} win_page_u;

	typedef struct packed {
		logic      romnram;
		logic      wrdisable;
		win_page_u page;
	} win_cfg_t;

	// request toward the memory arbiter
	// ROM uses addr[18:0] only
	typedef struct packed {
		logic        valid;
		logic        rom;
		logic        rnw;
		logic [21:0] addr;
		logic [7:0]  wdata;
	} mem_req_t;

endpackage

/* hw/win_pager.sv */
/*
 one 16 KB window pager; holds page byte, ROM/RAM flag and write disable
 loaded from the F7/FB/BF ports addressed to this window
*/
module win_pager #(
	parameter int unsigned WIN_IDX = 0
) (
	input  logic               fclk,
	input  logic               rst_n,
	input  zmem_pkg::port_wr_t port_wr,
	output zmem_pkg::win_cfg_t cfg
);
	import zmem_pkg::*;

	logic win_hit;

	// high two address bits select the window
	assign win_hit = port_wr.valid && (port_wr.addr[15:14] == 2'(WIN_IDX));

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			cfg.wrdisable <= 1'b0;
			if (WIN_IDX == 0)
			begin
				// boot ROM page 0, DOS ROM follows the flag
				cfg.romnram                <= 1'b1;
				cfg.page.rom.reserved      <= 2'b00;
				cfg.page.rom.dos_follow    <= 1'b1;
				cfg.page.rom.rom_page      <= 5'd0;
			end
			else
			begin
				cfg.romnram       <= 1'b0;
				cfg.page.ram.page <= 8'(WIN_IDX);
			end
		end
		else if (win_hit)
		begin
			case (port_wr.addr[7:0])
				PORT_RAM_PAGE:
				begin
					cfg.romnram       <= 1'b0;
					cfg.page.ram.page <= port_wr.data;
				end
				PORT_ROM_PAGE:
				begin
					cfg.romnram  <= 1'b1;
					cfg.page.rom <= rom_view_t'(port_wr.data);
				end
				PORT_WRDIS:
				begin
					cfg.wrdisable <= port_wr.data[0];
				end
				default:
				begin
					// other ports belong to someone else
					cfg <= cfg;
				end
			endcase
		end
	end

endmodule

/* hw/dos_ctrl.sv */
/*
 DOS flag; set by a ROM opcode fetch from 3Dxx, cleared by a fetch at 4000h or above
*/
module dos_ctrl (
	input  logic               fclk,
	input  logic               rst_n,
	input  zmem_pkg::cpu_acc_t cpu_acc,
	input  logic               acc_taken,
	input  logic               win0_romnram,
	output logic               dos
);
	import zmem_pkg::*;

	logic fetch;
	logic set_dos;
	logic clr_dos;

	// only accepted M1 cycles count
	assign fetch = acc_taken & cpu_acc.m1;

	// 3Dxx lies in window 0, so that window has to hold ROM
	assign set_dos = fetch & win0_romnram & (cpu_acc.addr[15:8] == DOS_TRAP_HI);

	// anything outside window 0 leaves DOS
	assign clr_dos = fetch & (cpu_acc.addr[15:14] != 2'b00);

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			dos <= 1'b0;
		end
		else if (set_dos)
		begin
			dos <= 1'b1;
		end
		else if (clr_dos)
		begin
			dos <= 1'b0;
		end
	end

endmodule

/* hw/credit_ctrl.sv */
/*
 credit counter toward the memory arbiter; one credit per issued request
 cpu_ready is registered and gates new CPU accesses
*/
module credit_ctrl #(
	parameter int unsigned MEM_CREDITS = 4
) (
	input  logic fclk,
	input  logic rst_n,
	input  logic req_issued,
	input  logic mem_credit,
	output logic cpu_ready
);
	localparam int unsigned CW = $clog2(MEM_CREDITS + 1);

	logic [CW-1:0] cnt;
	logic [CW-1:0] cnt_next;

	// spend and return may land together
	always_comb
	begin
		case ({req_issued, mem_credit})
			2'b10:   cnt_next = cnt - 1'b1;
			2'b01:   cnt_next = cnt + 1'b1;
			default: cnt_next = cnt;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// counter and ready
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			cnt       <= CW'(MEM_CREDITS);
			cpu_ready <= 1'b1;
		end
		else
		begin
			cnt <= cnt_next;
			// an access taken while ready is high only issues next cycle,
			// so keep one credit back for it
			cpu_ready <= (cnt_next > CW'(cpu_ready));
		end
	end

endmodule

/* hw/mem_mapper.sv */
/*
 maps a CPU access through the selected window into a ROM or DRAM request
 writes to write-disabled windows are accepted and dropped
*/
module mem_mapper (
	input  logic               fclk,
	input  logic               rst_n,
	input  zmem_pkg::cpu_acc_t cpu_acc,
	input  logic               cpu_ready,
	input  zmem_pkg::win_cfg_t win_cfg [4],
	input  logic               dos,
	output logic               acc_taken,
	output zmem_pkg::mem_req_t mem_req
);
	import zmem_pkg::*;

	win_cfg_t    sel;
	rom_view_t   rom_v;
	logic [4:0]  rom_pg;
	logic [13:0] offset;
	logic        wr_blocked;
	mem_req_t    req_d;
	mem_req_t    req_q;
	logic        req_vld;

	assign acc_taken = cpu_acc.valid & cpu_ready;
	assign offset    = cpu_acc.addr[13:0];

	////////////////////////////////////////////////////////////////////////////
	// window select and page decode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		sel   = win_cfg[cpu_acc.addr[15:14]];
		rom_v = sel.page.rom;

		// bit 0 picks basic/DOS ROM when following the flag
		if (rom_v.dos_follow)
		begin
			rom_pg = {rom_v.rom_page[4:1], dos};
		end
		else
		begin
			rom_pg = rom_v.rom_page;
		end

		wr_blocked = ~cpu_acc.rnw & sel.wrdisable;
	end

	always_comb
	begin
		req_d.valid = acc_taken & ~wr_blocked;
		req_d.rom   = sel.romnram;
		req_d.rnw   = cpu_acc.rnw;
		req_d.wdata = cpu_acc.wdata;
		if (sel.romnram)
		begin
			// 512 KB ROM space
			req_d.addr = {3'b000, rom_pg, offset};
		end
		else
		begin
			// 4 MB DRAM space
			req_d.addr = {sel.page.ram.page, offset};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// request register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			req_vld <= 1'b0;
		end
		else
		begin
			req_vld <= req_d.valid;
		end
	end

	// payload only, loaded on every taken access
	always_ff @(posedge fclk)
	begin
		if (acc_taken)
		begin
			req_q <= req_d;
		end
	end

	always_comb
	begin
		mem_req       = req_q;
		mem_req.valid = req_vld;
	end

endmodule

/* hw/zmem_top.sv */
/*
 Z80 memory paging path: four window pagers, DOS flag, credit control, mapper
 CPU accesses in, credit-controlled memory requests out
*/
module zmem_top #(
	parameter int unsigned MEM_CREDITS = 4
) (
	input  logic               fclk,
	input  logic               rst_n,
	input  zmem_pkg::cpu_acc_t cpu_acc,
	input  zmem_pkg::port_wr_t port_wr,
	input  logic               mem_credit,
	output logic               cpu_ready,
	output zmem_pkg::mem_req_t mem_req,
	output logic               dos
);
	import zmem_pkg::*;

	win_cfg_t win_cfg [4];
	logic     acc_taken;

	////////////////////////////////////////////////////////////////////////////
	// window pagers
	////////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < 4; i++)
	begin : g_pager
		win_pager #(
			.WIN_IDX(i)
		) win_pager_inst (
			.fclk   (fclk),
			.rst_n  (rst_n),
			.port_wr(port_wr),
			.cfg    (win_cfg[i])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// DOS flag and credits
	////////////////////////////////////////////////////////////////////////////

	dos_ctrl dos_ctrl_inst (
		.fclk        (fclk),
		.rst_n       (rst_n),
		.cpu_acc     (cpu_acc),
		.acc_taken   (acc_taken),
		.win0_romnram(win_cfg[0].romnram),
		.dos         (dos)
	);

	credit_ctrl #(
		.MEM_CREDITS(MEM_CREDITS)
	) credit_ctrl_inst (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.req_issued(mem_req.valid),
		.mem_credit(mem_credit),
		.cpu_ready (cpu_ready)
	);

	// address mapper
	mem_mapper mem_mapper_inst (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.cpu_acc  (cpu_acc),
		.cpu_ready(cpu_ready),
		.win_cfg  (win_cfg),
		.dos      (dos),
		.acc_taken(acc_taken),
		.mem_req  (mem_req)
	);

endmodule

/* testbench/zmem_assert.sv */
/*
 credit counter assertions, bound into credit_ctrl by the testbench
*/
module zmem_assert #(
	parameter int unsigned MEM_CREDITS = 4
) (
	input logic                               fclk,
	input logic                               rst_n,
	input logic                               req_issued,
	input logic                               mem_credit,
	input logic                               cpu_ready,
	input logic [$clog2(MEM_CREDITS + 1)-1:0] cnt
);
	// number of failed assertions
	int unsigned fails = 0;

	a_cnt_limit: assert property (@(posedge fclk) disable iff (!rst_n)
		cnt <= MEM_CREDITS)
	else
	begin
		$error("credit counter above MEM_CREDITS");
		fails++;
	end

	// a request may only spend a credit that exists
	a_no_underflow: assert property (@(posedge fclk) disable iff (!rst_n)
		(req_issued && !mem_credit) |-> (cnt != '0))
	else
	begin
		$error("request issued with no credit left");
		fails++;
	end

	a_no_overflow: assert property (@(posedge fclk) disable iff (!rst_n)
		(mem_credit && !req_issued) |-> (cnt != MEM_CREDITS))
	else
	begin
		$error("credit returned while counter already full");
		fails++;
	end

	// a credit back into an empty counter reopens the CPU side
	a_ready_back: assert property (@(posedge fclk) disable iff (!rst_n)
		(cnt == '0 && mem_credit && !req_issued) |=> cpu_ready)
	else
	begin
		$error("cpu_ready stayed low after a credit came back");
		fails++;
	end

endmodule

/* testbench/tb_zmem.sv */
/*
 testbench for the Z80 paging path; a stimulus table checked against a window model
 credits come back after a random delay, except in one held section
*/
module tb_zmem;
	import zmem_pkg::*;

	localparam int unsigned MEM_CREDITS = 4;
	localparam int          WAIT_LIMIT  = 64;
	localparam int          STALL_CYC   = 4;

	// port write and/or access, what should come out, credit section flags
	typedef struct packed {
		port_wr_t pw;
		cpu_acc_t acc;
		mem_req_t exp_req;
		logic     exp_dos;
		logic     hold;
		logic     stall;
	} row_t;

	logic     fclk;
	logic     rst_n;
	cpu_acc_t cpu_acc;
	port_wr_t port_wr;
	logic     mem_credit;
	logic     cpu_ready;
	mem_req_t mem_req;
	logic     dos;

	row_t rows [64];
	int   n_rows;
	int   n_exp_req;

	// window state model
	logic       m_rom [4];
	logic       m_wrdis [4];
	logic [7:0] m_page [4];
	logic       m_dos;
	logic       sec_hold;
	logic       sec_stall;

	// credit return bookkeeping
	int     owed = 0;
	int     issued = 0;
	int     gap = 0;
	int     manual_ask = 0;
	int     manual_done = 0;
	logic   hold_credits = 1'b0;
	integer seed = 32'h3592;

	int req_errs = 0;
	int dos_errs = 0;
	int flow_errs = 0;
	int timeouts = 0;

	zmem_top #(
		.MEM_CREDITS(MEM_CREDITS)
	) zmem_top_inst (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.cpu_acc   (cpu_acc),
		.port_wr   (port_wr),
		.mem_credit(mem_credit),
		.cpu_ready (cpu_ready),
		.mem_req   (mem_req),
		.dos       (dos)
	);

	bind credit_ctrl zmem_assert #(
		.MEM_CREDITS(MEM_CREDITS)
	) zmem_assert_inst (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.req_issued(req_issued),
		.mem_credit(mem_credit),
		.cpu_ready (cpu_ready),
		.cnt       (cnt)
	);

	initial
	begin
		fclk = 1'b0;
		forever #10 fclk = ~fclk;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model and table
	////////////////////////////////////////////////////////////////////////////

	function automatic mem_req_t model_access(input cpu_acc_t a);
		mem_req_t   r;
		logic [1:0] w;
		logic [4:0] pg;
		w = a.addr[15:14];
		r = '0;
		r.valid = a.rnw | ~m_wrdis[w];
		r.rom   = m_rom[w];
		r.rnw   = a.rnw;
		r.wdata = a.wdata;
		pg = m_page[w][4:0];
		// ROM byte bit 5 lets page bit 0 track DOS
		if (m_page[w][5])
			pg[0] = m_dos;
		if (m_rom[w])
			r.addr = {3'b000, pg, a.addr[13:0]};
		else
			r.addr = {m_page[w], a.addr[13:0]};
		if (!r.valid)
			r = '0;
		return r;
	endfunction

	task automatic push_row(input port_wr_t pw, input cpu_acc_t acc);
		row_t r;
		r = '0;
		r.pw  = pw;
		r.acc = acc;
		// access sees the windows before the port write of the same cycle
		if (acc.valid)
		begin
			r.exp_req = model_access(acc);
			if (acc.m1 && acc.addr[15:8] == DOS_TRAP_HI && m_rom[0])
				m_dos = 1'b1;
			else if (acc.m1 && acc.addr >= 16'h4000)
				m_dos = 1'b0;
		end
		if (pw.valid)
		begin
			case (pw.addr[7:0])
				PORT_RAM_PAGE:
				begin
					m_page[pw.addr[15:14]] = pw.data;
					m_rom[pw.addr[15:14]]  = 1'b0;
				end
				PORT_ROM_PAGE:
				begin
					m_page[pw.addr[15:14]] = pw.data;
					m_rom[pw.addr[15:14]]  = 1'b1;
				end
				PORT_WRDIS: m_wrdis[pw.addr[15:14]] = pw.data[0];
				default: ;
			endcase
		end
		r.exp_dos = m_dos;
		r.hold    = sec_hold;
		r.stall   = sec_stall;
		rows[n_rows] = r;
		n_rows++;
		if (r.exp_req.valid)
			n_exp_req++;
	endtask

	task automatic port_row(input logic [1:0] win, input logic [7:0] code, input logic [7:0] data);
		port_wr_t pw;
		pw.valid = 1'b1;
		pw.addr  = {win, 6'h00, code};
		pw.data  = data;
		push_row(pw, '0);
	endtask

	task automatic access_row(input logic rnw, input logic m1, input logic [15:0] addr,
		input logic [7:0] wdata);
		cpu_acc_t acc;
		acc.valid = 1'b1;
		acc.rnw   = rnw;
		acc.m1    = m1;
		acc.addr  = addr;
		acc.wdata = wdata;
		push_row('0, acc);
	endtask

	// read in the same cycle as a port write
	task automatic port_access_row(input logic [1:0] win, input logic [7:0] code,
		input logic [7:0] data, input logic [15:0] addr);
		port_wr_t pw;
		cpu_acc_t acc;
		pw  = '{valid: 1'b1, addr: {win, 6'h00, code}, data: data};
		acc = '{valid: 1'b1, rnw: 1'b1, m1: 1'b0, addr: addr, wdata: 8'h00};
		push_row(pw, acc);
	endtask

	task automatic build_table();
		int i;
		for (i = 0; i < 4; i++)
		begin
			m_rom[i]   = (i == 0);
			m_wrdis[i] = 1'b0;
			m_page[i]  = (i == 0) ? 8'h20 : 8'(i);
		end
		m_dos = 1'b0;
		sec_hold = 1'b0;
		sec_stall = 1'b0;
		n_rows = 0;
		n_exp_req = 0;
		// reset mapping
		access_row(1, 0, 16'h0000, 0);
		access_row(1, 0, 16'h1234, 0);
		access_row(1, 0, 16'h4001, 0);
		access_row(1, 0, 16'h8ABC, 0);
		access_row(1, 0, 16'hC123, 0);
		// page ports
		port_row(1, PORT_RAM_PAGE, 8'h25);
		access_row(1, 0, 16'h4010, 0);
		port_row(2, PORT_ROM_PAGE, 8'h0A);
		access_row(1, 0, 16'h8020, 0);
		port_row(3, PORT_RAM_PAGE, 8'hC3);
		access_row(0, 0, 16'hC005, 8'h55);
		port_row(0, PORT_ROM_PAGE, 8'h07);
		access_row(1, 0, 16'h0100, 0);
		port_access_row(1, PORT_RAM_PAGE, 8'h30, 16'h4100);
		access_row(1, 0, 16'h4100, 0);
		port_access_row(0, PORT_ROM_PAGE, 8'h24, 16'h0200);
		access_row(1, 0, 16'h0200, 0);
		port_row(2, PORT_RAM_PAGE, 8'hFF);
		access_row(1, 0, 16'hBFFF, 0);
		// write disable on window 1
		port_row(1, PORT_WRDIS, 8'h01);
		access_row(0, 0, 16'h4200, 8'hA1);
		access_row(1, 0, 16'h4200, 0);
		access_row(0, 0, 16'h8000, 8'hA2);
		access_row(0, 0, 16'hC200, 8'hA3);
		port_row(1, PORT_WRDIS, 8'h00);
		access_row(0, 0, 16'h4300, 8'hA4);
		// DOS flag
		access_row(1, 0, 16'h3D00, 0);
		access_row(1, 1, 16'h3D2F, 0);
		access_row(1, 0, 16'h0010, 0);
		access_row(1, 1, 16'h1000, 0);
		access_row(1, 1, 16'h8000, 0);
		access_row(1, 0, 16'h0010, 0);
		port_row(0, PORT_RAM_PAGE, 8'h12);
		access_row(1, 1, 16'h3D00, 0);
		port_row(0, PORT_ROM_PAGE, 8'h20);
		// credits held back, then one returned, then all
		sec_hold = 1'b1;
		for (i = 0; i < 4; i++)
			access_row(1, 0, 16'hC000 + 16'(i), 0);
		sec_stall = 1'b1;
		access_row(1, 0, 16'hC004, 0);
		sec_hold = 1'b0;
		access_row(1, 0, 16'hC005, 0);
		sec_stall = 1'b0;
		access_row(0, 0, 16'h4400, 8'hB0);
		access_row(1, 1, 16'h3D40, 0);
		access_row(1, 0, 16'h0040, 0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checks and waits
	////////////////////////////////////////////////////////////////////////////

	task automatic check_req(input mem_req_t got, input mem_req_t exp, input int row);
		if (got.valid !== exp.valid || (exp.valid && got !== exp))
		begin
			$display("FAILED %0t: row %0d mem_req %h, expected %h", $time, row, got, exp);
			req_errs++;
		end
	endtask

	task automatic check_dos(input logic got, input logic exp, input int row);
		if (got !== exp)
		begin
			$display("FAILED %0t: row %0d dos %b, expected %b", $time, row, got, exp);
			dos_errs++;
		end
	endtask

	task automatic check_ready(input logic got, input logic exp, input int row);
		if (got !== exp)
		begin
			$display("FAILED %0t: row %0d cpu_ready %b, expected %b", $time, row, got, exp);
			flow_errs++;
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
		begin
			$display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, exp);
			flow_errs++;
		end
	endtask

	// access stays valid while waiting
	task automatic wait_ready(input int row, output logic ok);
		int n;
		n = 0;
		while (cpu_ready !== 1'b1 && n < WAIT_LIMIT)
		begin
			@(negedge fclk);
			n++;
		end
		ok = (cpu_ready === 1'b1);
		if (!ok)
		begin
			$display("timeout at %0t: cpu_ready never came back for row %0d", $time, row);
			timeouts++;
		end
	endtask

	task automatic drain_credits(output logic ok);
		int n;
		n = 0;
		@(negedge fclk);
		while (owed != 0 && n < WAIT_LIMIT)
		begin
			@(negedge fclk);
			n++;
		end
		ok = (owed == 0);
		if (!ok)
		begin
			$display("timeout at %0t: %0d credits were never returned", $time, owed);
			timeouts++;
		end
		// counter takes the last credit
		@(negedge fclk);
	endtask

	// no access taken and no request while credits are out
	task automatic stall_check(input int row);
		int k;
		check_ready(cpu_ready, 1'b0, row);
		for (k = 0; k < STALL_CYC; k++)
		begin
			@(negedge fclk);
			check_ready(cpu_ready, 1'b0, row);
			check_req(mem_req, '0, row);
		end
		check_count(owed, MEM_CREDITS, "requests in flight at stall");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// credit return and stimulus
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		mem_credit = 1'b0;
		forever
		begin
			@(negedge fclk);
			mem_credit = 1'b0;
			if (rst_n && mem_req.valid === 1'b1)
			begin
				owed++;
				issued++;
			end
			if (owed > 0 && (manual_ask > manual_done || (!hold_credits && gap == 0)))
			begin
				mem_credit = 1'b1;
				owed--;
				if (manual_ask > manual_done)
					manual_done++;
				gap = {$random(seed)} % 4;
			end
			else if (gap > 0)
				gap--;
		end
	end

	initial
	begin
		logic ok;
		row_t r;
		int   i;
		int   asserts;
		rst_n   = 1'b0;
		cpu_acc = '0;
		port_wr = '0;
		build_table();
		repeat (4) @(negedge fclk);
		rst_n = 1'b1;
		check_ready(cpu_ready, 1'b1, -1);
		check_req(mem_req, '0, -1);
		check_dos(dos, 1'b0, -1);
		ok = 1'b1;
		for (i = 0; i < n_rows && ok; i++)
		begin
			r = rows[i];
			if (r.hold && !hold_credits)
				drain_credits(ok);
			if (ok)
			begin
				cpu_acc = r.acc;
				if (r.stall)
					stall_check(i);
				hold_credits <= r.hold;
				if (r.stall && r.hold)
					manual_ask <= manual_ask + 1;
				if (r.acc.valid)
					wait_ready(i, ok);
			end
			if (ok)
			begin
				port_wr = r.pw;
				@(negedge fclk);
				cpu_acc = '0;
				port_wr = '0;
				check_req(mem_req, r.exp_req, i);
				check_dos(dos, r.exp_dos, i);
			end
		end
		cpu_acc = '0;
		port_wr = '0;
		if (ok)
		begin
			drain_credits(ok);
			check_count(issued, n_exp_req, "requests issued");
		end
		asserts = zmem_top_inst.credit_ctrl_inst.zmem_assert_inst.fails;
		$display("errors: req %0d, dos %0d, flow %0d, timeouts %0d, assertions %0d",
			req_errs, dos_errs, flow_errs, timeouts, asserts);
		if (req_errs + dos_errs + flow_errs + timeouts + asserts == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* all.f */
hw/zmem_pkg.sv
hw/win_pager.sv
hw/dos_ctrl.sv
hw/credit_ctrl.sv
hw/mem_mapper.sv
hw/zmem_top.sv
testbench/zmem_assert.sv
testbench/tb_zmem.sv

/* Bender.yml */
package:
  name: zmem

sources:
  - files:
      - hw/zmem_pkg.sv
      - hw/win_pager.sv
      - hw/dos_ctrl.sv
      - hw/credit_ctrl.sv
      - hw/mem_mapper.sv
      - hw/zmem_top.sv
  - target: test
    files:
      - testbench/zmem_assert.sv
      - testbench/tb_zmem.sv
